// File: logic/pipeline_pkg.sv
package pipeline_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int data_width    = 64;   // Register and ALU width
  localparam int addr_width    = 64;   // PC width
  localparam int inst_width    = 32;
  localparam int reg_idx_width = 5;

  localparam logic [reg_idx_width-1:0] zero_reg = 5'd31;  // Reads zero, drops writes

  // Primary opcodes
  localparam logic [5:0] op_inta = 6'h10;  // Integer arithmetic
  localparam logic [5:0] op_intl = 6'h11;  // Integer logical
  localparam logic [5:0] op_lda  = 6'h08;
  localparam logic [5:0] op_pal  = 6'h00;  // call_pal

  // Operate function codes, qualified by opcode
  localparam logic [6:0] func_addq  = 7'h20;
  localparam logic [6:0] func_subq  = 7'h29;
  localparam logic [6:0] func_cmpeq = 7'h2d;
  localparam logic [6:0] func_and   = 7'h00;
  localparam logic [6:0] func_bis   = 7'h20;
  localparam logic [6:0] func_xor   = 7'h40;

  localparam logic [25:0] pal_halt = 26'd0;  // call_pal function for halt

  ////////////////////////////////////////
  // Control encodings
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_cmpeq, alu_and, alu_or, alu_xor
  } alu_func_t;

  typedef enum logic [1:0] {
    opb_reg,      // rb value
    opb_literal,  // Zero-extended 8-bit literal
    opb_disp      // Sign-extended 16-bit displacement
  } opb_select_t;

  typedef enum logic [1:0] {
    no_error, halted_on_halt, halted_on_illegal
  } status_t;

  // One instruction word, two decodings
  // rb of the operate view lives in literal[7:3]
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      logic [7:0] literal;   // Upper five bits double as rb
      logic       lit_flag;  // Set selects literal over rb
      logic [6:0] func;
      logic [4:0] rc;
    } operate_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [15:0] disp;
    } memory_fmt;
  } inst_t;

  localparam inst_t nop_inst = 32'h47ff_041f;  // bis r31,r31,r31

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             halted,
  input  logic                             imem_ack,
  input  pipeline_pkg::inst_t              imem_data,
  output logic                             imem_req,
  output logic [pipeline_pkg::addr_width-1:0] imem_addr,
  output pipeline_pkg::inst_t              if_inst,
  output logic [pipeline_pkg::addr_width-1:0] if_npc,
  output logic                             if_valid
);
  import pipeline_pkg::*;

  logic [addr_width-1:0] pc;
  logic [addr_width-1:0] npc;
  logic                  capture;    // Ack seen while requesting
  inst_t                 buf_inst;   // Capture buffer
  logic [addr_width-1:0] buf_npc;
  logic                  buf_valid;

  assign npc       = pc + addr_width'(4);
  assign capture   = imem_req && imem_ack;
  assign imem_addr = pc;  // Only moves when req drops

  ////////////////////////////////////////
  // Four-phase request
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      imem_req <= 1'b0;
      pc       <= '0;
    end
    else if (capture)
    begin
      imem_req <= 1'b0;  // Phase 3, release
      pc       <= npc;
    end
    else if (!imem_req && !imem_ack && !halted)
      imem_req <= 1'b1;  // Ack low seen, next request
  end

  // Capture edge, then fetch/decode register one cycle later
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      buf_inst  <= nop_inst;
      buf_valid <= 1'b0;
      if_inst   <= nop_inst;
      if_valid  <= 1'b0;
    end
    else
    begin
      buf_valid <= capture;
      if (capture)
        buf_inst <= imem_data;
      if_inst  <= buf_inst;
      if_valid <= buf_valid && !halted;  // Late words after halt dropped
    end
  end

  always_ff @(posedge clock)
  begin
    if (capture)
      buf_npc <= npc;
    if_npc <= buf_npc;
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic                                clock,
  input  logic [pipeline_pkg::reg_idx_width-1:0] rd_idx_a,
  input  logic [pipeline_pkg::reg_idx_width-1:0] rd_idx_b,
  input  logic                                wr_en,
  input  logic [pipeline_pkg::reg_idx_width-1:0] wr_idx,
  input  logic [pipeline_pkg::data_width-1:0]    wr_data,
  output logic [pipeline_pkg::data_width-1:0]    rd_data_a,
  output logic [pipeline_pkg::data_width-1:0]    rd_data_b
);
  import pipeline_pkg::*;

  logic [data_width-1:0] regs [0:31];  // Contents undefined until written

  // Shared read path with write-through of a same-cycle write
  function automatic logic [data_width-1:0] read_port(input logic [reg_idx_width-1:0] idx);
    if (idx == zero_reg)
      return '0;
    else if (wr_en && wr_idx == idx)
      return wr_data;   // Bypass the new value
    else
      return regs[idx];
  endfunction

  always_comb
  begin
    rd_data_a = read_port(rd_idx_a);
    rd_data_b = read_port(rd_idx_b);
  end

  always_ff @(posedge clock)
  begin
    if (wr_en && wr_idx != zero_reg)
      regs[wr_idx] <= wr_data;
  end

endmodule

// File: logic/instruction_decoder.sv
`timescale 1ns/1ns

module instruction_decoder (
  input  pipeline_pkg::inst_t                   inst,
  input  logic                                  valid,
  output pipeline_pkg::alu_func_t               alu_func,
  output pipeline_pkg::opb_select_t             opb_select,
  output logic [pipeline_pkg::reg_idx_width-1:0] dest_idx,
  output logic                                  halt,
  output logic                                  illegal
);
  import pipeline_pkg::*;

  logic [25:0] pal_func;  // call_pal function field

  assign pal_func = {inst.memory_fmt.ra, inst.memory_fmt.rb, inst.memory_fmt.disp};

  always_comb
  begin
    // Inactive defaults, also the bubble case
    alu_func   = alu_add;
    opb_select = opb_reg;
    dest_idx   = zero_reg;
    halt       = 1'b0;
    illegal    = 1'b0;
    if (valid)
    begin
      case (inst.operate_fmt.opcode)
        op_inta, op_intl:
        begin
          opb_select = inst.operate_fmt.lit_flag ? opb_literal : opb_reg;
          dest_idx   = inst.operate_fmt.rc;
          if (inst.operate_fmt.opcode == op_inta)
          begin
            case (inst.operate_fmt.func)
              func_addq:  alu_func = alu_add;
              func_subq:  alu_func = alu_sub;
              func_cmpeq: alu_func = alu_cmpeq;
              default:    illegal  = 1'b1;
            endcase
          end
          else
          begin
            case (inst.operate_fmt.func)
              func_and: alu_func = alu_and;
              func_bis: alu_func = alu_or;
              func_xor: alu_func = alu_xor;
              default:  illegal  = 1'b1;
            endcase
          end
        end
        op_lda:
        begin
          opb_select = opb_disp;             // rb + sext(disp)
          dest_idx   = inst.memory_fmt.ra;
        end
        op_pal:
          if (pal_func == pal_halt)
            halt = 1'b1;
          else
            illegal = 1'b1;                  // Only halt is kept
        default:
          illegal = 1'b1;
      endcase
      if (illegal)
        dest_idx = zero_reg;                 // Never writes
    end
  end

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
  input  logic                                   clock,
  input  logic                                   reset,
  input  pipeline_pkg::inst_t                    inst,
  input  logic [pipeline_pkg::addr_width-1:0]    npc,
  input  logic                                   valid,
  input  logic [pipeline_pkg::data_width-1:0]    rega,
  input  logic [pipeline_pkg::data_width-1:0]    regb,
  input  pipeline_pkg::alu_func_t                alu_func,
  input  pipeline_pkg::opb_select_t              opb_select,
  input  logic [pipeline_pkg::reg_idx_width-1:0] dest_idx,
  input  logic                                   halt,
  input  logic                                   illegal,
  output logic [pipeline_pkg::data_width-1:0]    ex_result,
  output logic [pipeline_pkg::reg_idx_width-1:0] ex_dest_idx,
  output logic [pipeline_pkg::addr_width-1:0]    ex_npc,
  output logic                                   ex_valid,
  output logic                                   ex_halt,
  output logic                                   ex_illegal
);
  import pipeline_pkg::*;

  inst_t                 de_inst;
  logic [data_width-1:0] de_rega;
  logic [data_width-1:0] de_regb;
  alu_func_t             de_alu_func;
  opb_select_t           de_opb_select;
  logic [data_width-1:0] opa;
  logic [data_width-1:0] opb;

  ////////////////////////////////////////
  // Decode/execute register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      de_inst       <= nop_inst;
      de_alu_func   <= alu_or;     // Matches the nop
      de_opb_select <= opb_reg;
      ex_dest_idx   <= zero_reg;
      ex_valid      <= 1'b0;
      ex_halt       <= 1'b0;
      ex_illegal    <= 1'b0;
    end
    else
    begin
      de_inst       <= inst;
      de_alu_func   <= alu_func;
      de_opb_select <= opb_select;
      ex_dest_idx   <= dest_idx;
      ex_valid      <= valid;
      ex_halt       <= halt;
      ex_illegal    <= illegal;
    end
  end

  always_ff @(posedge clock)
  begin
    de_rega <= rega;
    de_regb <= regb;
    ex_npc  <= npc;
  end

  // lda base is rb, operate uses ra
  assign opa = (de_opb_select == opb_disp) ? de_regb : de_rega;

  always_comb
  begin
    case (de_opb_select)
      opb_literal: opb = {{(data_width - 8){1'b0}}, de_inst.operate_fmt.literal};
      opb_disp:    opb = {{(data_width - 16){de_inst.memory_fmt.disp[15]}},
                          de_inst.memory_fmt.disp};
      default:     opb = de_regb;
    endcase
  end

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  always_comb
  begin
    case (de_alu_func)
      alu_sub:   ex_result = opa - opb;
      alu_cmpeq: ex_result = {{(data_width - 1){1'b0}}, opa == opb};  // 1 or 0
      alu_and:   ex_result = opa & opb;
      alu_or:    ex_result = opa | opb;
      alu_xor:   ex_result = opa ^ opb;
      default:   ex_result = opa + opb;  // addq and lda
    endcase
  end

endmodule

// File: logic/commit_unit.sv
`timescale 1ns/1ns

module commit_unit (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [pipeline_pkg::data_width-1:0]    ex_result,
  input  logic [pipeline_pkg::reg_idx_width-1:0] ex_dest_idx,
  input  logic [pipeline_pkg::addr_width-1:0]    ex_npc,
  input  logic                                   ex_valid,
  input  logic                                   ex_halt,
  input  logic                                   ex_illegal,
  output logic                                   commit_wr_en,
  output logic [pipeline_pkg::reg_idx_width-1:0] commit_wr_idx,
  output logic [pipeline_pkg::data_width-1:0]    commit_wr_data,
  output logic [pipeline_pkg::addr_width-1:0]    commit_npc,
  output logic [3:0]                             completed_insts,
  output pipeline_pkg::status_t                  error_status,
  output logic                                   halted
);
  import pipeline_pkg::*;

  ////////////////////////////////////////
  // Execute/commit register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      commit_wr_en    <= 1'b0;
      completed_insts <= 4'd0;
      error_status    <= no_error;
    end
    else
    begin
      // r31 and illegal words never write
      commit_wr_en    <= ex_valid && !ex_illegal && ex_dest_idx != zero_reg;
      completed_insts <= {3'b000, ex_valid};  // Halting word counts too
      if (error_status == no_error && ex_valid)
      begin
        if (ex_illegal)
          error_status <= halted_on_illegal;
        else if (ex_halt)
          error_status <= halted_on_halt;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    commit_wr_idx  <= ex_dest_idx;
    commit_wr_data <= ex_result;
    commit_npc     <= ex_npc;
  end

  assign halted = (error_status != no_error);  // Sticky with the status

endmodule

// File: logic/pipeline.sv
`timescale 1ns/1ns

module pipeline (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   imem_ack,
  input  pipeline_pkg::inst_t                    imem_data,
  output logic                                   imem_req,
  output logic [pipeline_pkg::addr_width-1:0]    imem_addr,
  output logic                                   commit_wr_en,
  output logic [pipeline_pkg::reg_idx_width-1:0] commit_wr_idx,
  output logic [pipeline_pkg::data_width-1:0]    commit_wr_data,
  output logic [pipeline_pkg::addr_width-1:0]    commit_npc,
  output logic [3:0]                             completed_insts,
  output pipeline_pkg::status_t                  error_status
);
  import pipeline_pkg::*;

  // Fetch/decode
  inst_t                    if_inst;
  logic [addr_width-1:0]    if_npc;
  logic                     if_valid;
  // Decode results, side by side
  logic [data_width-1:0]    rega;
  logic [data_width-1:0]    regb;
  alu_func_t                alu_func;
  opb_select_t              opb_select;
  logic [reg_idx_width-1:0] dest_idx;
  logic                     dec_halt;
  logic                     dec_illegal;
  // Execute
  logic [data_width-1:0]    ex_result;
  logic [reg_idx_width-1:0] ex_dest_idx;
  logic [addr_width-1:0]    ex_npc;
  logic                     ex_valid;
  logic                     ex_halt;
  logic                     ex_illegal;
  logic                     halted;   // Commit back to fetch

  fetch_unit i_fetch (
    .clock, .reset, .halted, .imem_ack, .imem_data,
    .imem_req, .imem_addr, .if_inst, .if_npc, .if_valid
  );

  register_file i_regfile (
    .clock,
    .rd_idx_a  (if_inst.memory_fmt.ra),  // Same bits in both views
    .rd_idx_b  (if_inst.memory_fmt.rb),
    .wr_en     (commit_wr_en),
    .wr_idx    (commit_wr_idx),
    .wr_data   (commit_wr_data),
    .rd_data_a (rega),
    .rd_data_b (regb)
  );

  instruction_decoder i_decoder (
    .inst (if_inst), .valid (if_valid), .alu_func, .opb_select, .dest_idx,
    .halt (dec_halt), .illegal (dec_illegal)
  );

  execute_unit i_execute (
    .clock, .reset, .inst (if_inst), .npc (if_npc), .valid (if_valid),
    .rega, .regb, .alu_func, .opb_select, .dest_idx,
    .halt (dec_halt), .illegal (dec_illegal),
    .ex_result, .ex_dest_idx, .ex_npc, .ex_valid, .ex_halt, .ex_illegal
  );

  commit_unit i_commit (
    .clock, .reset, .ex_result, .ex_dest_idx, .ex_npc, .ex_valid, .ex_halt,
    .ex_illegal, .commit_wr_en, .commit_wr_idx, .commit_wr_data, .commit_npc,
    .completed_insts, .error_status, .halted
  );

endmodule

// File: sim/pipeline_properties.sv
`timescale 1ns/1ns

module pipeline_properties (
  input logic                                   clock,
  input logic                                   reset,
  input logic                                   imem_req,
  input logic                                   imem_ack,
  input logic [pipeline_pkg::addr_width-1:0]    imem_addr,
  input logic                                   commit_wr_en,
  input logic [pipeline_pkg::reg_idx_width-1:0] commit_wr_idx,
  input pipeline_pkg::status_t                  error_status
);
  import pipeline_pkg::*;

  ////////////////////////////////////////
  // Instruction memory handshake
  ////////////////////////////////////////
  req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
    imem_req && !imem_ack |=> imem_req)
    else $error("imem_req dropped before imem_ack was seen");

  addr_stable: assert property (@(posedge clock) disable iff (reset)
    imem_req && $past(imem_req) |-> $stable(imem_addr))  // PC moves only on release
    else $error("imem_addr changed while imem_req was high");

  // Commit side
  no_r31_write: assert property (@(posedge clock) disable iff (reset)
    !(commit_wr_en && commit_wr_idx == zero_reg))
    else $error("commit_wr_en high with index 31");

  no_fetch_after_halt: assert property (@(posedge clock) disable iff (reset)
    error_status != no_error |=> !$rose(imem_req))
    else $error("imem_req rose after the pipeline halted");

endmodule

// File: sim/pipeline_tb.sv
`timescale 1ns/1ns

module pipeline_tb;
  import pipeline_pkg::*;

  localparam int max_insts   = 32;
  localparam int wait_limit  = 100;  // Cycles per wait
  localparam int idle_window = 40;   // Quiet cycles expected after a halt

  logic                     clock;
  logic                     reset;
  logic                     imem_ack;
  inst_t                    imem_data;
  logic                     imem_req;
  logic [addr_width-1:0]    imem_addr;
  logic                     commit_wr_en;
  logic [reg_idx_width-1:0] commit_wr_idx;
  logic [data_width-1:0]    commit_wr_data;
  logic [addr_width-1:0]    commit_npc;
  logic [3:0]               completed_insts;
  status_t                  error_status;

  // Program table with one row per instruction
  logic [inst_width-1:0]    prog_word  [0:max_insts-1];
  logic                     exp_wr_en  [0:max_insts-1];
  logic [reg_idx_width-1:0] exp_idx    [0:max_insts-1];
  logic [data_width-1:0]    exp_data   [0:max_insts-1];
  status_t                  exp_status [0:max_insts-1];
  logic [data_width-1:0]    ref_regs   [0:31];  // Reference register model
  int                       prog_len;
  integer                   seed;
  int                       errors;
  int                       tests_run;
  int                       tests_failed;

  pipeline i_pipeline (
    .clock, .reset, .imem_ack, .imem_data, .imem_req, .imem_addr,
    .commit_wr_en, .commit_wr_idx, .commit_wr_data, .commit_npc,
    .completed_insts, .error_status
  );

  bind pipeline pipeline_properties i_properties (
    .clock (clock), .reset (reset), .imem_req (imem_req), .imem_ack (imem_ack),
    .imem_addr (imem_addr), .commit_wr_en (commit_wr_en),
    .commit_wr_idx (commit_wr_idx), .error_status (error_status)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////
  function automatic logic [31:0] operate(input logic [5:0] op, input logic [6:0] func,
                                          input logic [4:0] ra, input logic [4:0] rb,
                                          input logic [4:0] rc);
    return {op, ra, rb, 3'b000, 1'b0, func, rc};
  endfunction

  function automatic logic [31:0] operate_lit(input logic [5:0] op, input logic [6:0] func,
                                              input logic [4:0] ra, input logic [7:0] lit,
                                              input logic [4:0] rc);
    return {op, ra, lit, 1'b1, func, rc};
  endfunction

  function automatic logic [31:0] lda_word(input logic [4:0] ra, input logic [4:0] rb,
                                           input logic [15:0] disp);
    return {op_lda, ra, rb, disp};
  endfunction

  function automatic logic [data_width-1:0] ref_read(input logic [4:0] idx);
    return (idx == zero_reg) ? '0 : ref_regs[idx];
  endfunction

  // Appends a word and its expected commit and updates the reference model
  task automatic add_inst(input logic [31:0] word);
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] r;
    logic [4:0]            dest;
    logic                  legal;
    a     = ref_read(word[25:21]);
    b     = word[12] ? {56'd0, word[20:13]} : ref_read(word[20:16]);
    r     = '0;
    dest  = word[4:0];  // rc
    legal = 1'b1;
    exp_status[prog_len] = no_error;
    case (word[31:26])
      op_inta:
        case (word[11:5])
          func_addq:  r = a + b;
          func_subq:  r = a - b;
          func_cmpeq: r = (a == b) ? 64'd1 : 64'd0;
          default:    legal = 1'b0;
        endcase
      op_intl:
        case (word[11:5])
          func_and: r = a & b;
          func_bis: r = a | b;
          func_xor: r = a ^ b;
          default:  legal = 1'b0;
        endcase
      op_lda:
      begin
        r    = ref_read(word[20:16]) + {{48{word[15]}}, word[15:0]};
        dest = word[25:21];  // ra
      end
      op_pal:
      begin
        dest  = zero_reg;
        legal = (word[25:0] == 26'd0);
        if (legal)
          exp_status[prog_len] = halted_on_halt;
      end
      default: legal = 1'b0;
    endcase
    if (!legal)
    begin
      dest = zero_reg;
      exp_status[prog_len] = halted_on_illegal;
    end
    prog_word[prog_len] = word;
    exp_wr_en[prog_len] = (dest != zero_reg);
    exp_idx[prog_len]   = dest;
    exp_data[prog_len]  = r;
    if (dest != zero_reg)
      ref_regs[dest] = r;
    prog_len++;
  endtask

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic finish_run();
    $display("%0d tests, %0d with errors, %0d errors in all", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    errors++;
    finish_run();
  endtask

  task automatic flag_wrong_value(input string name, input int i, input logic [63:0] got,
                                  input logic [63:0] want);
    $display("mismatch %s at instruction %0d: got %h, expected %h", name, i, got, want);
    errors++;
  endtask

  task automatic report_test(input string label, input int start_errors);
    tests_run++;
    if (errors != start_errors)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, label, (errors == start_errors) ? "ok" : "error");
  endtask

  ////////////////////////////////////////
  // Memory responder
  ////////////////////////////////////////
  task automatic serve_one();
    int delay;
    int cycles;
    if (imem_addr[1:0] == 2'b00 && imem_addr < 64'(prog_len * 4))
      imem_data = prog_word[imem_addr[6:2]];
    else
      imem_data = nop_inst;  // Past the end of the program
    delay = 1 + int'($unsigned($random(seed)) % 3);
    repeat (delay) @(posedge clock);
    #1;
    imem_ack = 1'b1;
    cycles   = 0;
    do
    begin
      @(posedge clock);
      #1;
      cycles++;
    end while (imem_req && cycles < wait_limit);
    if (imem_req)
      abort_run("timeout: imem_req stayed high after imem_ack");
    else
      imem_ack = 1'b0;  // Phase 4
  endtask

  // Serves requests until the pipeline halts with no request open
  task automatic serve_program();
    int   cycles;
    int   served;
    logic done;
    done   = 1'b0;
    served = 0;
    while (!done)
    begin
      cycles = 0;
      do
      begin
        @(posedge clock);
        #1;
        cycles++;
      end while (!imem_req && error_status == no_error && cycles < wait_limit);
      if (imem_req && served > prog_len)
        abort_run("the fetch unit kept fetching past the end of the program");
      else if (imem_req)
      begin
        serve_one();
        served++;
      end
      else if (error_status != no_error)
        done = 1'b1;
      else
        abort_run("timeout: the fetch unit raised no instruction request");
    end
  endtask

  ////////////////////////////////////////
  // Commit monitor
  ////////////////////////////////////////
  task automatic check_commits();
    int                    cycles;
    int                    start_errors;
    logic [addr_width-1:0] exp_npc;
    for (int i = 0; i < prog_len; i++)
    begin
      cycles = 0;
      do
      begin
        @(posedge clock);
        #1;
        cycles++;
      end while (completed_insts == 4'd0 && cycles < wait_limit);
      if (completed_insts == 4'd0)
        abort_run($sformatf("timeout: instruction %0d never committed", i));
      else
      begin
        start_errors = errors;
        exp_npc      = 64'(i + 1) << 2;
        if (completed_insts !== 4'd1)
          flag_wrong_value("completed_insts", i, 64'(completed_insts), 64'd1);
        if (commit_wr_en !== exp_wr_en[i])
          flag_wrong_value("commit_wr_en", i, 64'(commit_wr_en), 64'(exp_wr_en[i]));
        if (exp_wr_en[i] && commit_wr_idx !== exp_idx[i])
          flag_wrong_value("commit_wr_idx", i, 64'(commit_wr_idx), 64'(exp_idx[i]));
        if (exp_wr_en[i] && commit_wr_data !== exp_data[i])
          flag_wrong_value("commit_wr_data", i, commit_wr_data, exp_data[i]);
        if (commit_npc !== exp_npc)
          flag_wrong_value("commit_npc", i, commit_npc, exp_npc);
        if (error_status !== exp_status[i])
          flag_wrong_value("error_status", i, 64'(error_status), 64'(exp_status[i]));
        report_test($sformatf("commit %0d word %h", i, prog_word[i]), start_errors);
      end
    end
  endtask

  // No new request and no further commit after a halt
  task automatic check_idle_after_halt();
    int start_errors;
    int req_cycles;
    int extra_commits;
    start_errors  = errors;
    req_cycles    = 0;
    extra_commits = 0;
    repeat (idle_window)
    begin
      @(posedge clock);
      #1;
      if (imem_req)
        req_cycles++;
      if (completed_insts != 4'd0)
        extra_commits++;
    end
    if (req_cycles != 0)
    begin
      $display("imem_req was raised again after the pipeline halted");
      errors++;
    end
    if (extra_commits != 0)
    begin
      $display("an instruction committed after the halting one");
      errors++;
    end
    report_test("quiet after halt", start_errors);
  endtask

  task automatic run_program();
    fork
      serve_program();
      check_commits();
    join
    check_idle_after_halt();
  endtask

  task automatic reset_dut();
    reset    = 1'b1;
    imem_ack = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    reset    = 1'b0;
    prog_len = 0;
  endtask

  initial
  begin
    seed         = 33285;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    prog_len     = 0;
    reset        = 1'b1;
    imem_ack     = 1'b0;
    imem_data    = nop_inst;
    reset_dut();
    // Constants from r31 with one negative
    add_inst(lda_word(5'd1, 5'd31, 16'h1234));
    add_inst(lda_word(5'd2, 5'd31, 16'hfffe));
    add_inst(lda_word(5'd3, 5'd31, 16'h7fff));
    add_inst(lda_word(5'd4, 5'd31, 16'h8000));
    // Dependent chain in register form
    add_inst(operate(op_inta, func_addq, 5'd1, 5'd2, 5'd5));
    add_inst(operate(op_inta, func_subq, 5'd5, 5'd3, 5'd6));
    add_inst(operate(op_intl, func_and, 5'd6, 5'd1, 5'd7));
    add_inst(operate(op_intl, func_bis, 5'd7, 5'd4, 5'd8));
    add_inst(operate(op_intl, func_xor, 5'd8, 5'd2, 5'd9));
    add_inst(operate(op_inta, func_cmpeq, 5'd9, 5'd9, 5'd10));   // True
    add_inst(operate(op_inta, func_cmpeq, 5'd9, 5'd1, 5'd11));   // False
    // Literal forms
    add_inst(operate_lit(op_inta, func_addq, 5'd1, 8'hff, 5'd12));
    add_inst(operate_lit(op_inta, func_subq, 5'd12, 8'h10, 5'd13));
    add_inst(operate_lit(op_intl, func_and, 5'd13, 8'hf0, 5'd14));
    add_inst(operate_lit(op_intl, func_bis, 5'd14, 8'h0f, 5'd15));
    add_inst(operate_lit(op_intl, func_xor, 5'd15, 8'haa, 5'd16));
    add_inst(operate_lit(op_inta, func_cmpeq, 5'd31, 8'h00, 5'd17));
    add_inst(operate_lit(op_inta, func_cmpeq, 5'd1, 8'h34, 5'd18));
    // r31 as destination and then as source
    add_inst(operate(op_inta, func_addq, 5'd1, 5'd2, 5'd31));
    add_inst(operate(op_inta, func_addq, 5'd31, 5'd1, 5'd19));
    add_inst(32'h0000_0000);  // call_pal halt
    run_program();
    reset_dut();
    add_inst(lda_word(5'd1, 5'd31, 16'h0007));
    add_inst(operate_lit(op_inta, func_addq, 5'd1, 8'h01, 5'd2));
    add_inst({6'h3f, 5'd1, 5'd2, 16'h0003});  // Undefined opcode
    run_program();
    finish_run();
  end

endmodule

// File: all.f
logic/pipeline_pkg.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/instruction_decoder.sv
logic/execute_unit.sv
logic/commit_unit.sv
logic/pipeline.sv
sim/pipeline_properties.sv
sim/pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := pipeline_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
